//--- src/dsp_io_pkg.sv
`default_nettype none

package dsp_io_pkg;

    // bus and register widths
    localparam int io_data_w = 16;
    localparam int io_addr_w = 3;

    // core register map, bit 2 picks the unit
    localparam logic [io_addr_w-1:0] addr_pioc = 3'd0;  // parallel control/status
    localparam logic [io_addr_w-1:0] addr_pdx0 = 3'd1;
    localparam logic [io_addr_w-1:0] addr_pdx1 = 3'd2;
    localparam logic [io_addr_w-1:0] addr_srta = 3'd4;  // serial tx data
    localparam logic [io_addr_w-1:0] addr_sdx  = 3'd5;  // serial rx data
    localparam logic [io_addr_w-1:0] addr_sioc = 3'd6;  // serial status

    // writable pioc field
    localparam int pioc_msb = 14;
    localparam int pioc_lsb = 5;

    // stlen=0, output and input modes set, no interrupt enables
    localparam logic [io_data_w-1:0] pioc_rst = 16'h1800;

    // interrupt enables inside pioc
    localparam int ien_irq_bit = 5;
    localparam int ien_rd_bit  = 8;  // serial receive full
    localparam int ien_wr_bit  = 9;  // serial transmit empty

    localparam int stlen_lsb = 13;  // two-bit strobe length

    // serial status word
    localparam int sioc_full_bit  = 0;
    localparam int sioc_empty_bit = 1;

endpackage

`default_nettype wire

//--- src/dsp_pio.sv
`timescale 1ns/1ps
`default_nettype none

// parallel port, active mode only: both strobes are driven from here
module dsp_pio (
    input  wire                             rst,
    input  wire                             clk,
    input  wire                             cen,
    input  wire [dsp_io_pkg::io_data_w-1:0] pbus_in,
    input  wire                             pdx_read,
    input  wire [dsp_io_pkg::io_data_w-1:0] long_imm,
    input  wire                             pio_imm_load,
    input  wire [dsp_io_pkg::io_addr_w-1:0] r_field,
    input  wire                             siord_full,
    input  wire                             siowr_empty,
    input  wire                             irq,
    input  wire                             iack,
    output logic [dsp_io_pkg::io_data_w-1:0] pbus_out,
    output logic                            pods_n,    // output data strobe
    output logic                            pids_n,    // input data strobe
    output logic                            psel,      // 0 = pdx0, 1 = pdx1
    output logic [dsp_io_pkg::io_data_w-1:0] pio_dout,
    output logic                            irq_latch
);
    import dsp_io_pkg::*;

    logic [pioc_msb:pioc_lsb] pioc;       // bit 15 of the read word mirrors bit 4
    logic [io_data_w-1:0]     pdx0_rd;    // captured input words
    logic [io_data_w-1:0]     pdx1_rd;
    logic [3:0]               pocnt;      // strobe timers, bit 0 is the strobe
    logic [3:0]               picnt;
    logic                     last_irq;
    logic                     last_empty;
    logic                     last_full;
    logic                     last_iack;
    logic [4:0]               status;

    wire [1:0] stlen   = pioc[stlen_lsb+1:stlen_lsb];
    // zeros shifted in from the bottom, one per low tick
    wire [3:0] ststart = 4'b1110 << stlen;

    wire pioc_load  = pio_imm_load && r_field == addr_pioc;
    wire pdx_load   = pio_imm_load && (r_field == addr_pdx0 || r_field == addr_pdx1);
    wire pdx_access = pdx_load || pdx_read;

    // last low tick of the input strobe
    wire capture = !picnt[0] && picnt[1];

    // interrupt sources, gated by their enables
    wire irq_en     = irq & pioc[ien_irq_bit];
    wire irq_rise   = irq_en & ~last_irq;
    wire empty_rise = siowr_empty & ~last_empty & pioc[ien_wr_bit];
    wire full_rise  = siord_full & ~last_full & pioc[ien_rd_bit];
    wire iack_fall  = ~iack & last_iack;

    assign pods_n = pocnt[0];
    assign pids_n = picnt[0];

    // bits 2:1 belong to passive mode, not supported
    assign status = {siowr_empty, siord_full, 2'b00, irq_en};

    always_comb begin
        case (r_field)
            addr_pioc: pio_dout = {status[4], pioc, status};
            addr_pdx1: pio_dout = pdx1_rd;
            default:   pio_dout = pdx0_rd;
        endcase
    end

    // edge detectors and the interrupt latch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_irq   <= 1'b0;
            last_empty <= 1'b1;  // tx buffer leaves reset empty, no false edge
            last_full  <= 1'b0;
            last_iack  <= 1'b0;
            irq_latch  <= 1'b0;
        end else if (cen) begin
            last_irq   <= irq_en;
            last_empty <= siowr_empty;
            last_full  <= siord_full;
            last_iack  <= iack;
            if (irq_rise || empty_rise || full_rise) begin
                irq_latch <= 1'b1;  // a new request beats the acknowledge
            end else if (iack_fall) begin
                irq_latch <= 1'b0;
            end
        end
    end

    // strobe timers, select line, output bus and control register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pocnt    <= 4'hf;
            picnt    <= 4'hf;
            psel     <= 1'b0;
            pbus_out <= '0;
            pioc     <= pioc_rst[pioc_msb:pioc_lsb];
        end else if (cen) begin
            // a new access restarts its strobe
            pocnt <= pdx_load ? ststart : {1'b1, pocnt[3:1]};
            picnt <= pdx_read ? ststart : {1'b1, picnt[3:1]};
            if (pdx_access) begin
                psel <= r_field == addr_pdx1;
            end
            if (pdx_load) begin
                pbus_out <= long_imm;  // bus updates with the strobe edge
            end
            if (pioc_load) begin
                pioc <= long_imm[pioc_msb:pioc_lsb];  // mode bits kept, not acted on
            end
        end
    end

    // capture buffers
    always_ff @(posedge clk) begin
        if (cen && capture) begin
            if (psel) begin
                pdx1_rd <= pbus_in;
            end else begin
                pdx0_rd <= pbus_in;
            end
        end
    end

    // output bus only moves together with a fresh output strobe
    a_pbus_hold: assert property (
        @(posedge clk) disable iff (rst)
        !$stable(pbus_out) |-> !pods_n
    ) else $error("pbus_out changed without an output strobe");

endmodule

`default_nettype wire

//--- src/dsp_sio.sv
`timescale 1ns/1ps
`default_nettype none

// full duplex serial port, tx and rx shifters share one frame timer
module dsp_sio #(
    parameter int bit_ticks = 2  // cen ticks per serial bit
) (
    input  wire                              rst,
    input  wire                              clk,
    input  wire                              cen,
    input  wire                              sio_wr,
    input  wire                              sio_rd,
    input  wire  [dsp_io_pkg::io_data_w-1:0] sio_wdata,
    input  wire                              sdi,
    output logic [dsp_io_pkg::io_data_w-1:0] sio_rdata,
    output logic                             siowr_empty,
    output logic                             siord_full,
    output logic                             sdo,
    output logic                             sfs
);
    import dsp_io_pkg::*;

    localparam int tick_w = $clog2(bit_ticks + 1);
    localparam int bit_w  = $clog2(io_data_w);

    logic [tick_w-1:0]    tick_cnt;  // ticks into the current bit
    logic [bit_w-1:0]     bit_cnt;   // bit within the frame
    logic                 busy;      // frame in progress
    logic [io_data_w-1:0] tx_buf;
    logic [io_data_w-1:0] tx_shift;
    logic [io_data_w-1:0] rx_shift;
    logic [io_data_w-1:0] rx_buf;

    wire bit_end   = busy && tick_cnt == tick_w'(bit_ticks - 1);
    wire frame_end = bit_end && bit_cnt == bit_w'(io_data_w - 1);
    // shifter free now or at the end of this tick
    wire load_shift = !siowr_empty && (!busy || frame_end);

    assign sdo       = busy & tx_shift[io_data_w-1];  // msb first, low when idle
    assign sfs       = bit_cnt == '0;  // also high between frames
    assign sio_rdata = rx_buf;

    // frame timing and flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_cnt    <= '0;
            bit_cnt     <= '0;
            busy        <= 1'b0;
            siowr_empty <= 1'b1;
            siord_full  <= 1'b0;
        end else if (cen) begin
            if (load_shift) begin
                busy     <= 1'b1;  // back to back frames when the buffer is ready
                tick_cnt <= '0;
                bit_cnt  <= '0;
            end else if (busy) begin
                if (bit_end) begin
                    tick_cnt <= '0;
                    bit_cnt  <= bit_cnt + 1'b1;  // wraps to zero at frame end
                    if (frame_end) begin
                        busy <= 1'b0;
                    end
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
            // empty flag, a write on the load tick refills it
            if (load_shift) begin
                siowr_empty <= 1'b1;
            end
            if (sio_wr) begin
                siowr_empty <= 1'b0;
            end
            // full flag, a new word wins over a read
            if (sio_rd) begin
                siord_full <= 1'b0;
            end
            if (frame_end) begin
                siord_full <= 1'b1;
            end
        end
    end

    // data path
    always_ff @(posedge clk) begin
        if (cen) begin
            if (sio_wr) begin
                tx_buf <= sio_wdata;  // overwrites a word not yet taken
            end
            if (load_shift) begin
                tx_shift <= tx_buf;
            end else if (bit_end) begin
                tx_shift <= {tx_shift[io_data_w-2:0], 1'b0};
            end
            // sample on the last tick of each bit
            if (bit_end) begin
                rx_shift <= {rx_shift[io_data_w-2:0], sdi};
            end
            if (frame_end) begin
                rx_buf <= {rx_shift[io_data_w-2:0], sdi};
            end
        end
    end

    // frame sync only comes back up once a frame has been completed
    a_sfs_first: assert property (
        @(posedge clk) disable iff (rst)
        $rose(sfs) |-> $past(cen && frame_end)
    ) else $error("sfs rose inside a frame");

endmodule

`default_nettype wire

//--- src/dsp_io_decode.sv
`timescale 1ns/1ps
`default_nettype none

// core register access decoder and read data mux
module dsp_io_decode (
    input  wire  [dsp_io_pkg::io_addr_w-1:0] io_addr,
    input  wire                              io_wr,
    input  wire                              io_rd,
    input  wire  [dsp_io_pkg::io_data_w-1:0] io_wdata,
    input  wire  [dsp_io_pkg::io_data_w-1:0] pio_dout,
    input  wire  [dsp_io_pkg::io_data_w-1:0] sio_rdata,
    input  wire                              siowr_empty,
    input  wire                              siord_full,
    output logic [dsp_io_pkg::io_data_w-1:0] io_rdata,
    output logic                             pio_imm_load,
    output logic                             pdx_read,
    output logic [dsp_io_pkg::io_addr_w-1:0] r_field,
    output logic [dsp_io_pkg::io_data_w-1:0] long_imm,
    output logic                             sio_wr,
    output logic                             sio_rd,
    output logic [dsp_io_pkg::io_data_w-1:0] sio_wdata
);
    import dsp_io_pkg::*;

    logic [io_data_w-1:0] sio_status;

    wire pio_sel = !io_addr[2];  // low half of the map
    wire sio_sel = io_addr[2];

    // parallel port strobes
    assign pio_imm_load = io_wr && pio_sel;
    assign pdx_read     = io_rd && pio_sel && (io_addr == addr_pdx0 || io_addr == addr_pdx1);
    assign r_field      = io_addr;
    assign long_imm     = io_wdata;

    // serial port strobes, only the data registers
    assign sio_wr    = io_wr && sio_sel && io_addr[1:0] == addr_srta[1:0];
    assign sio_rd    = io_rd && sio_sel && io_addr[1:0] == addr_sdx[1:0];  // clears full
    assign sio_wdata = io_wdata;

    always_comb begin
        sio_status                 = '0;
        sio_status[sioc_empty_bit] = siowr_empty;
        sio_status[sioc_full_bit]  = siord_full;
    end

    // read data follows the address directly
    always_comb begin
        if (pio_sel) begin
            io_rdata = pio_dout;
        end else begin
            case (io_addr)
                addr_sdx:  io_rdata = sio_rdata;
                addr_sioc: io_rdata = sio_status;
                default:   io_rdata = '0;  // srta is write only
            endcase
        end
    end

    // one access per cycle from the core
    always_comb begin
        a_one_access: assert final (!(io_wr && io_rd))
            else $error("io_wr and io_rd both high");
    end

endmodule

`default_nettype wire

//--- src/dsp_io_top.sv
`timescale 1ns/1ps
`default_nettype none

// i/o subsystem: decoder, parallel port, serial port
module dsp_io_top #(
    parameter int bit_ticks = 2
) (
    input  wire                              rst,
    input  wire                              clk,
    input  wire                              cen,
    // core side
    input  wire  [dsp_io_pkg::io_addr_w-1:0] io_addr,
    input  wire                              io_wr,
    input  wire                              io_rd,
    input  wire  [dsp_io_pkg::io_data_w-1:0] io_wdata,
    input  wire                              irq_ack,
    output logic [dsp_io_pkg::io_data_w-1:0] io_rdata,
    output logic                             io_irq,
    // parallel side
    input  wire  [dsp_io_pkg::io_data_w-1:0] pbus_in,
    input  wire                              irq_ext,
    output logic [dsp_io_pkg::io_data_w-1:0] pbus_out,
    output logic                             psel,
    output logic                             pods_n,
    output logic                             pids_n,
    // serial side
    input  wire                              sdi,
    output logic                             sdo,
    output logic                             sfs
);
    import dsp_io_pkg::*;

    wire                 pio_imm_load;
    wire                 pdx_read;
    wire [io_addr_w-1:0] r_field;
    wire [io_data_w-1:0] long_imm;
    wire [io_data_w-1:0] pio_dout;
    wire                 sio_wr;
    wire                 sio_rd;
    wire [io_data_w-1:0] sio_wdata;
    wire [io_data_w-1:0] sio_rdata;
    wire                 siowr_empty;  // also an interrupt source
    wire                 siord_full;

    dsp_io_decode u_decode (
        .io_addr      (io_addr),
        .io_wr        (io_wr),
        .io_rd        (io_rd),
        .io_wdata     (io_wdata),
        .pio_dout     (pio_dout),
        .sio_rdata    (sio_rdata),
        .siowr_empty  (siowr_empty),
        .siord_full   (siord_full),
        .io_rdata     (io_rdata),
        .pio_imm_load (pio_imm_load),
        .pdx_read     (pdx_read),
        .r_field      (r_field),
        .long_imm     (long_imm),
        .sio_wr       (sio_wr),
        .sio_rd       (sio_rd),
        .sio_wdata    (sio_wdata)
    );

    dsp_pio u_pio (
        .rst          (rst),
        .clk          (clk),
        .cen          (cen),
        .pbus_in      (pbus_in),
        .pdx_read     (pdx_read),
        .long_imm     (long_imm),
        .pio_imm_load (pio_imm_load),
        .r_field      (r_field),
        .siord_full   (siord_full),
        .siowr_empty  (siowr_empty),
        .irq          (irq_ext),
        .iack         (irq_ack),
        .pbus_out     (pbus_out),
        .pods_n       (pods_n),
        .pids_n       (pids_n),
        .psel         (psel),
        .pio_dout     (pio_dout),
        .irq_latch    (io_irq)
    );

    dsp_sio #(
        .bit_ticks (bit_ticks)
    ) u_sio (
        .rst         (rst),
        .clk         (clk),
        .cen         (cen),
        .sio_wr      (sio_wr),
        .sio_rd      (sio_rd),
        .sio_wdata   (sio_wdata),
        .sdi         (sdi),
        .sio_rdata   (sio_rdata),
        .siowr_empty (siowr_empty),
        .siord_full  (siord_full),
        .sdo         (sdo),
        .sfs         (sfs)
    );

endmodule

`default_nettype wire

//--- tb/dsp_io_periph.sv
`timescale 1ns/1ps
`default_nettype none

// external device on the parallel and serial pins
module dsp_io_periph (
    input  wire         psel,
    input  wire         pids_n,
    input  wire         sdo,
    output logic [15:0] pbus_in,
    output logic        sdi
);

    logic [7:0] strobe_cnt;  // input strobes seen so far

    initial begin
        strobe_cnt = 8'd0;
    end

    // one count per input strobe
    always @(negedge pids_n) begin
        strobe_cnt <= strobe_cnt + 8'd1;
    end

    // tag byte tells pdx0 from pdx1, low byte is the strobe number
    always_comb begin
        if (pids_n) begin
            pbus_in = 16'h0000;  // bus released between strobes
        end else if (psel) begin
            pbus_in = {8'hb1, strobe_cnt};
        end else begin
            pbus_in = {8'ha0, strobe_cnt};
        end
    end

    assign sdi = sdo;  // serial loopback

endmodule

`default_nettype wire

//--- tb/dsp_io_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_io_tb;
    import dsp_io_pkg::*;

    localparam int bit_ticks   = 2;
    localparam int frame_ticks = io_data_w * bit_ticks;
    // strobe loops, eight serial frames, then slack for polling
    localparam int est_ticks   = 4 * 60 + 8 * (frame_ticks + 10) + 200;
    localparam int wd_cycles   = 4 * est_ticks;  // cen is high about half the time

    logic        clk;
    logic        rst;
    logic        cen;
    logic [2:0]  io_addr;
    logic        io_wr;
    logic        io_rd;
    logic [15:0] io_wdata;
    logic        irq_ack;
    logic [15:0] io_rdata;
    logic        io_irq;
    logic [15:0] pbus_in;
    logic        irq_ext;
    logic [15:0] pbus_out;
    logic        psel;
    logic        pods_n;
    logic        pids_n;
    logic        sdi;
    logic        sdo;
    logic        sfs;

    logic [15:0] lfsr_state;
    int          errors;
    int          n_in;          // input strobes issued
    logic [15:0] last_word[2];  // word the device drove in the last strobe
    logic        have[2];

    dsp_io_top #(.bit_ticks(bit_ticks)) UUT (
        .rst(rst), .clk(clk), .cen(cen),
        .io_addr(io_addr), .io_wr(io_wr), .io_rd(io_rd), .io_wdata(io_wdata),
        .irq_ack(irq_ack), .io_rdata(io_rdata), .io_irq(io_irq),
        .pbus_in(pbus_in), .irq_ext(irq_ext), .pbus_out(pbus_out),
        .psel(psel), .pods_n(pods_n), .pids_n(pids_n),
        .sdi(sdi), .sdo(sdo), .sfs(sfs)
    );

    dsp_io_periph u_periph (
        .psel(psel), .pids_n(pids_n), .sdo(sdo), .pbus_in(pbus_in), .sdi(sdi)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run("stopping at first mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            errors++;
            $display("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
            abort_run("stopping at first mismatch");
        end
    endtask

    // galois lfsr, taps 16,14,13,11
    function automatic logic draw_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
        return b;
    endfunction

    task automatic draw_word(output logic [15:0] w);
        for (int i = 0; i < 16; i++) begin
            w[i] = draw_bit();
        end
    endtask

    // status read word rebuilt from flags and stored pioc bits
    function automatic logic [15:0] pioc_expect(input logic [15:0] pv, input logic empty,
                                                input logic full, input logic irq_en);
        logic [15:0] w;
        w     = pv & 16'h7fe0;
        w[15] = empty;
        w[4]  = empty;
        w[3]  = full;
        w[0]  = irq_en;
        return w;
    endfunction

    // advance one clock, strobes drop, new cen drawn
    task automatic next_cycle();
        @(posedge clk);
        #10;
        io_wr = 1'b0;
        io_rd = 1'b0;
        cen   = draw_bit();
    endtask

    task automatic wait_ticks(input int n);
        int k;
        k = 0;
        while (k < n) begin
            if (cen) k++;
            next_cycle();
        end
    endtask

    // one core access on a cen cycle, read data sampled before the edge
    task automatic access(input logic [2:0] addr, input logic wr, input logic [15:0] data,
                          output logic [15:0] rdata);
        while (!cen) next_cycle();
        io_addr  = addr;
        io_wdata = data;
        io_wr    = wr;
        io_rd    = !wr;
        #1;
        rdata = io_rdata;
        next_cycle();
    endtask

    // cen ticks the strobe stays low
    task automatic strobe_low_ticks(input logic is_out, output int n);
        n = 0;
        while ((is_out ? pods_n : pids_n) == 1'b0) begin
            if (cen) n++;
            next_cycle();
        end
    endtask

    // poll the serial status until a received word shows up
    task automatic wait_rx_full(input int limit);
        int k;
        k = 0;
        io_addr = addr_sioc;
        #1;
        while (io_rdata[sioc_full_bit] == 1'b0 && k < limit) begin
            if (cen) k++;
            next_cycle();
            #1;
        end
        assert (io_rdata[sioc_full_bit]) else abort_run("no received word after a frame");
    endtask

    task automatic wait_irq_high(input int limit);
        int k;
        k = 0;
        while (!io_irq && k < limit) begin
            if (cen) k++;
            next_cycle();
        end
        assert (io_irq) else abort_run("io_irq did not rise after an enabled edge");
    endtask

    // ack pulse, latch clears on its falling edge only
    task automatic ack_irq();
        irq_ack = 1'b1;
        wait_ticks(2);
        check_bit("io_irq", io_irq, 1'b1);
        irq_ack = 1'b0;
        wait_ticks(2);
        check_bit("io_irq", io_irq, 1'b0);
    endtask

    initial begin
        #(wd_cycles * 100);
        abort_run("watchdog expired, DUT stopped responding");
    end

    initial begin
        logic [15:0] rd;
        logic [15:0] w;
        logic [15:0] pv;
        logic [15:0] exp;
        logic [2:0]  addr;
        int          n;
        lfsr_state = 16'd43;
        errors = 0;
        n_in = 0;
        have[0] = 1'b0;
        have[1] = 1'b0;
        rst      = 1'b1;
        cen      = 1'b0;
        io_addr  = 3'd0;
        io_wr    = 1'b0;
        io_rd    = 1'b0;
        io_wdata = 16'h0000;
        irq_ack  = 1'b0;
        irq_ext  = 1'b0;
        repeat (10) @(posedge clk);
        #10 rst = 1'b0;
        next_cycle();

        // reset state
        check_bit("pods_n", pods_n, 1'b1);
        check_bit("pids_n", pids_n, 1'b1);
        check_bit("sfs", sfs, 1'b1);
        check_bit("psel", psel, 1'b0);
        check_bit("io_irq", io_irq, 1'b0);
        access(addr_pioc, 1'b0, 16'h0000, rd);
        check_word("pioc read", rd, pioc_expect(pioc_rst, 1'b1, 1'b0, 1'b0));
        access(addr_sioc, 1'b0, 16'h0000, rd);
        exp = 16'h0000;
        exp[sioc_empty_bit] = 1'b1;
        check_word("sioc read", rd, exp);

        // every strobe length, output then input strobes
        for (int s = 0; s < 4; s++) begin
            pv = pioc_rst | (16'(s) << stlen_lsb);
            access(addr_pioc, 1'b1, pv, rd);
            access(addr_pioc, 1'b0, 16'h0000, rd);
            check_word("pioc read", rd, pioc_expect(pv, 1'b1, 1'b0, 1'b0));
            addr = s[0] ? addr_pdx1 : addr_pdx0;
            draw_word(w);
            access(addr, 1'b1, w, rd);
            check_word("pbus_out", pbus_out, w);
            check_bit("psel", psel, s[0]);
            strobe_low_ticks(1'b1, n);
            check_word("pods_n low ticks", 16'(n), 16'(s + 1));
            for (int sel = 0; sel < 2; sel++) begin
                addr = (sel == 1) ? addr_pdx1 : addr_pdx0;
                access(addr, 1'b0, 16'h0000, rd);
                if (have[sel]) check_word("pdx read", rd, last_word[sel]);
                n_in++;
                check_bit("psel", psel, sel[0]);
                strobe_low_ticks(1'b0, n);
                check_word("pids_n low ticks", 16'(n), 16'(s + 1));
                last_word[sel] = {(sel == 1) ? 8'hb1 : 8'ha0, 8'(n_in)};
                have[sel] = 1'b1;
            end
        end

        // serial loopback frames
        repeat (4) begin
            draw_word(w);
            access(addr_srta, 1'b1, w, rd);
            // one tick to load the idle shifter, then a whole frame
            wait_ticks(frame_ticks);
            access(addr_sioc, 1'b0, 16'h0000, rd);
            check_bit("sioc full", rd[sioc_full_bit], 1'b0);  // last bit still shifting
            access(addr_sioc, 1'b0, 16'h0000, rd);
            check_bit("sioc full", rd[sioc_full_bit], 1'b1);
            access(addr_sdx, 1'b0, 16'h0000, rd);
            check_word("sdx read", rd, w);
            access(addr_sioc, 1'b0, 16'h0000, rd);
            check_bit("sioc full", rd[sioc_full_bit], 1'b0);
        end

        // external irq
        access(addr_pioc, 1'b1, pioc_rst | (16'd1 << ien_irq_bit), rd);
        irq_ext = 1'b1;
        wait_irq_high(4);
        irq_ext = 1'b0;
        ack_irq();

        // transmit empty edge
        access(addr_pioc, 1'b1, pioc_rst | (16'd1 << ien_wr_bit), rd);
        draw_word(w);
        access(addr_srta, 1'b1, w, rd);
        wait_irq_high(8);
        ack_irq();
        wait_rx_full(frame_ticks + 10);
        access(addr_sdx, 1'b0, 16'h0000, rd);
        check_word("sdx read", rd, w);

        // receive full edge
        access(addr_pioc, 1'b1, pioc_rst | (16'd1 << ien_rd_bit), rd);
        draw_word(w);
        access(addr_srta, 1'b1, w, rd);
        wait_irq_high(frame_ticks + 20);
        ack_irq();
        access(addr_sdx, 1'b0, 16'h0000, rd);
        check_word("sdx read", rd, w);

        // all enables off, every source toggles
        access(addr_pioc, 1'b1, pioc_rst, rd);
        irq_ext = 1'b1;
        draw_word(w);
        access(addr_srta, 1'b1, w, rd);
        repeat (frame_ticks + 10) begin
            check_bit("io_irq", io_irq, 1'b0);
            wait_ticks(1);
        end
        irq_ext = 1'b0;
        wait_rx_full(frame_ticks + 10);
        access(addr_sdx, 1'b0, 16'h0000, rd);
        check_word("sdx read", rd, w);
        check_bit("io_irq", io_irq, 1'b0);

        if (errors == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            abort_run("checks failed");
        end
    end

endmodule

`default_nettype wire

//--- dsp_io_top.f
src/dsp_io_pkg.sv
src/dsp_pio.sv
src/dsp_sio.sv
src/dsp_io_decode.sv
src/dsp_io_top.sv
tb/dsp_io_periph.sv
tb/dsp_io_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the dsp_io testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f dsp_io_top.f \
    --top-module dsp_io_tb \
    -o dsp_io_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output="$(./obj_dir/dsp_io_sim 2>&1)"
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
    exit 0
else
    exit 1
fi
